/* all.f */
logic/alut_pkg.sv
logic/alut_regs.sv
logic/alut_addr_checker.sv
logic/alut_age_checker.sv
logic/alut_mem.sv
logic/alut_top.sv
tests/alut_properties.sv
tests/alut_tb.sv

/* logic/alut_addr_checker.sv */
module alut_addr_checker
(
   input  logic                             pclk4,
   input  logic                             n_p_reset4,
   input  alut_pkg::cmd_e                   command,
   input  logic [alut_pkg::addr_w-1:0]      mac_addr,
   input  logic [alut_pkg::addr_w-1:0]      d_addr,          // address to look up
   input  logic [alut_pkg::addr_w-1:0]      s_addr,          // address to learn
   input  logic [alut_pkg::port_w-1:0]      s_port,
   input  logic [alut_pkg::time_w-1:0]      curr_time,
   input  logic [alut_pkg::entry_w-1:0]     mem_rdata,
   input  logic                             age_confirmed,
   input  logic                             age_ok,
   input  logic                             clear_reused,
   output logic [alut_pkg::dport_w-1:0]     d_port,
   output logic                             add_check_active,
   output logic [alut_pkg::hash_w-1:0]      mem_addr,
   output logic                             mem_write,
   output logic [alut_pkg::entry_w-1:0]     mem_wdata,
   output logic [alut_pkg::addr_w-1:0]      lst_inv_addr,
   output logic [alut_pkg::port_w-1:0]      lst_inv_port,
   output logic                             check_age,       // one cycle request
   output logic [alut_pkg::time_w-1:0]      last_accessed,
   output logic                             reused
);

   alut_pkg::chk_state_e state, nxt_state;

   logic [alut_pkg::hash_w-1:0]  s_hash, d_hash;
   logic                         dest_vld_q;      // destination entry copy
   logic [alut_pkg::addr_w-1:0]  dest_addr_q;
   logic [alut_pkg::port_w-1:0]  dest_port_q;
   logic                         age_ok_q;
   logic                         dest_hit;
   logic [alut_pkg::dport_w-1:0] src_mask;        // source port never gets the frame
   logic                         reuse_hit;

   // xor of the six address bytes
   function automatic logic [alut_pkg::hash_w-1:0] byte_hash
      (input logic [alut_pkg::addr_w-1:0] addr);
      logic [alut_pkg::hash_w-1:0] h;
      h = '0;
      for (int i = 0; i < alut_pkg::addr_w / alut_pkg::hash_w; i++)
         h = h ^ addr[i*alut_pkg::hash_w +: alut_pkg::hash_w];
      return h;
   endfunction

   assign s_hash = byte_hash(s_addr);
   assign d_hash = byte_hash(d_addr);

   // --------------------------------------------------
   // lookup and learn fsm
   // --------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         alut_pkg::idle:
            if (command == alut_pkg::cmd_check)
               nxt_state = alut_pkg::mac_chk;
         alut_pkg::mac_chk:                        // frame for the switch itself
            nxt_state = (d_addr == mac_addr) ? alut_pkg::idle : alut_pkg::read_dest;
         alut_pkg::read_dest: nxt_state = alut_pkg::valid_chk;
         alut_pkg::valid_chk: nxt_state = alut_pkg::age_chk;
         alut_pkg::age_chk:                        // wait on the age checker
            if (age_confirmed)
               nxt_state = alut_pkg::addr_chk;
         alut_pkg::addr_chk:  nxt_state = alut_pkg::read_src;
         alut_pkg::read_src:  nxt_state = alut_pkg::write_src;
         alut_pkg::write_src: nxt_state = alut_pkg::idle;
         default:             nxt_state = alut_pkg::idle;
      endcase
   end

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         state <= alut_pkg::idle;
      else
         state <= nxt_state;
   end

   assign add_check_active = (state != alut_pkg::idle);

   // --------------------------------------------------
   // destination entry, held while the address moves to the source hash
   // --------------------------------------------------
   always_ff @(posedge pclk4)
   begin
      if ((state == alut_pkg::age_chk) && age_confirmed)
      begin
         dest_vld_q  <= mem_rdata[alut_pkg::ent_valid_bit];
         dest_addr_q <= mem_rdata[alut_pkg::addr_w-1:0];
         dest_port_q <= mem_rdata[alut_pkg::ent_port_lsb +: alut_pkg::port_w];
         age_ok_q    <= age_ok;                    // freshness of the same entry
      end
   end

   assign dest_hit = dest_vld_q && age_ok_q && (dest_addr_q == d_addr);
   assign src_mask = alut_pkg::dport_w'(1) << s_port;

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         d_port <= alut_pkg::dport_all;
      else if ((state == alut_pkg::mac_chk) && (d_addr == mac_addr))
         d_port <= alut_pkg::dport_cpu;
      else if (state == alut_pkg::addr_chk)
      begin
         if (dest_hit)
            d_port <= (alut_pkg::dport_w'(1) << dest_port_q) & ~src_mask;   // learned port
         else
            d_port <= alut_pkg::dport_all & ~src_mask;   // invalid, stale or other addr
      end
   end

   // --------------------------------------------------
   // table addressing and write
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         mem_addr  <= '0;
         mem_write <= 1'b0;
      end
      else
      begin
         mem_write <= (state == alut_pkg::read_src);   // high through write_src
         if (((state == alut_pkg::age_chk) && age_confirmed) ||
             (state == alut_pkg::addr_chk) || (state == alut_pkg::read_src))
            mem_addr <= s_hash;
         else
            mem_addr <= d_hash;                        // default points at destination
      end
   end

   // learned entries are always valid
   assign mem_wdata = {1'b1, curr_time, s_port, s_addr};

   // --------------------------------------------------
   // reused tracking on the source entry
   // --------------------------------------------------
   assign reuse_hit = (state == alut_pkg::read_src) && mem_rdata[alut_pkg::ent_valid_bit] &&
                      (mem_rdata[alut_pkg::addr_w-1:0] != s_addr);

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reuse_hit)                              // capture beats a clear
      begin
         reused       <= 1'b1;
         lst_inv_addr <= mem_rdata[alut_pkg::addr_w-1:0];
         lst_inv_port <= mem_rdata[alut_pkg::ent_port_lsb +: alut_pkg::port_w];
      end
      else if (clear_reused)
         reused <= 1'b0;
   end

   // --------------------------------------------------
   // age request, fired on entry to age_chk
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         check_age <= 1'b0;
      else
         check_age <= (state == alut_pkg::valid_chk);
   end

   always_ff @(posedge pclk4)
   begin
      if (state == alut_pkg::valid_chk)
         last_accessed <= mem_rdata[alut_pkg::ent_time_lsb +: alut_pkg::time_w];
   end

endmodule

/* logic/alut_age_checker.sv */
module alut_age_checker
(
   input  logic                          pclk4,
   input  logic                          n_p_reset4,
   input  logic                          check_age,       // request strobe
   input  logic [alut_pkg::time_w-1:0]   last_accessed,   // entry timestamp
   input  logic [alut_pkg::time_w-1:0]   max_age,
   output logic                          age_confirmed,   // answer strobe
   output logic                          age_ok,
   output logic [alut_pkg::time_w-1:0]   curr_time
);

   logic [alut_pkg::time_w-1:0] age;   // elapsed cycles, modular

   // --------------------------------------------------
   // time base
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;   // wraps freely
   end

   // wrap safe as long as real age stays under 2^32
   assign age = curr_time - last_accessed;

   // --------------------------------------------------
   // freshness answer, one cycle after request
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         if (check_age)
            age_ok <= (age <= max_age);   // held until next request
      end
   end

endmodule

/* logic/alut_mem.sv */
module alut_mem
(
   input  logic                             pclk4,
   input  logic                             n_p_reset4,
   input  logic [alut_pkg::hash_w-1:0]      mem_addr,
   input  logic                             mem_write,
   input  logic [alut_pkg::entry_w-1:0]     mem_wdata,
   output logic [alut_pkg::entry_w-1:0]     mem_rdata    // combinational read
);

   localparam int depth = 1 << alut_pkg::hash_w;

   logic [alut_pkg::entry_w-2:0] store [depth];   // time, port and address
   logic [depth-1:0]             vld;             // valid per entry

   always_ff @(posedge pclk4)
   begin
      if (mem_write)
         store[mem_addr] <= mem_wdata[alut_pkg::entry_w-2:0];
   end

   // empty table after reset
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         vld <= '0;
      else if (mem_write)
         vld[mem_addr] <= mem_wdata[alut_pkg::ent_valid_bit];
   end

   assign mem_rdata = {vld[mem_addr], store[mem_addr]};

endmodule

/* logic/alut_pkg.sv */
package alut_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int addr_w  = 48;          // mac address
   localparam int port_w  = 2;           // source port code
   localparam int time_w  = 32;          // timestamp
   localparam int entry_w = 83;          // valid + time + port + addr
   localparam int hash_w  = 8;           // table index for 256 entries
   localparam int dport_w = 5;           // cpu bit + four ethernet ports

   // entry layout with the address at the bottom
   localparam int ent_valid_bit = 82;
   localparam int ent_time_lsb  = 50;    // time in 81:50
   localparam int ent_port_lsb  = 48;    // port in 49:48

   // destination port vectors
   localparam logic [dport_w-1:0] dport_cpu = 5'b1_0000;   // switch cpu only
   localparam logic [dport_w-1:0] dport_all = 5'b0_1111;   // flood ethernet ports

   typedef enum logic [1:0] {cmd_none = 2'd0, cmd_check = 2'd1} cmd_e;

   // lookup and learn sequence
   typedef enum logic [2:0] {
      idle, mac_chk, read_dest, valid_chk, age_chk, addr_chk, read_src, write_src
   } chk_state_e;

   typedef enum logic [3:0] {
      ra_mac_lo = 4'd0, ra_mac_hi = 4'd1, ra_d_lo = 4'd2, ra_d_hi = 4'd3,
      ra_s_lo = 4'd4, ra_s_hi = 4'd5, ra_command = 4'd6, ra_max_age = 4'd7,
      ra_status = 4'd8, ra_d_port = 4'd9, ra_inv_lo = 4'd10, ra_inv_hi = 4'd11
   } reg_addr_e;

endpackage

/* logic/alut_regs.sv */
module alut_regs
(
   input  logic                             pclk4,
   input  logic                             n_p_reset4,
   input  logic                             reg_write,        // write strobe
   input  logic                             reg_read,         // read strobe
   input  logic [3:0]                       reg_addr,
   input  logic [31:0]                      reg_wdata,
   input  logic [alut_pkg::dport_w-1:0]     d_port,           // lookup result
   input  logic                             add_check_active,
   input  logic                             reused,
   input  logic [alut_pkg::addr_w-1:0]      lst_inv_addr,
   input  logic [alut_pkg::port_w-1:0]      lst_inv_port,
   output logic [31:0]                      reg_rdata,
   output logic [alut_pkg::addr_w-1:0]      mac_addr,         // switch own address
   output logic [alut_pkg::addr_w-1:0]      d_addr,
   output logic [alut_pkg::addr_w-1:0]      s_addr,
   output logic [alut_pkg::port_w-1:0]      s_port,
   output alut_pkg::cmd_e                   command,          // one cycle opcode
   output logic [alut_pkg::time_w-1:0]      max_age,
   output logic                             clear_reused
);

   logic wr_cmd;   // command register hit

   assign wr_cmd = reg_write && (reg_addr == alut_pkg::ra_command);

   // --------------------------------------------------
   // programmable fields
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         mac_addr <= '0;
         d_addr   <= '0;
         s_addr   <= '0;
         s_port   <= '0;
         max_age  <= '0;
      end
      else if (reg_write)
      begin
         case (reg_addr)
            alut_pkg::ra_mac_lo:  mac_addr[31:0] <= reg_wdata;
            alut_pkg::ra_mac_hi:  mac_addr[alut_pkg::addr_w-1:32] <= reg_wdata[15:0];
            alut_pkg::ra_d_lo:    d_addr[31:0] <= reg_wdata;
            alut_pkg::ra_d_hi:    d_addr[alut_pkg::addr_w-1:32] <= reg_wdata[15:0];
            alut_pkg::ra_s_lo:    s_addr[31:0] <= reg_wdata;
            alut_pkg::ra_s_hi:
            begin
               s_addr[alut_pkg::addr_w-1:32] <= reg_wdata[15:0];
               s_port <= reg_wdata[17:16];     // port rides above the address
            end
            alut_pkg::ra_max_age: max_age <= reg_wdata;
            default: ;                          // read only or unmapped
         endcase
      end
   end

   // plain pulse, the checker decides if it is taken
   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
         command <= alut_pkg::cmd_none;
      else if (wr_cmd)
         command <= alut_pkg::cmd_e'(reg_wdata[1:0]);
      else
         command <= alut_pkg::cmd_none;
   end

   // --------------------------------------------------
   // read side
   // --------------------------------------------------
   always_comb
   begin
      case (reg_addr)
         alut_pkg::ra_status: reg_rdata = {30'd0, reused, add_check_active};
         alut_pkg::ra_d_port: reg_rdata = {27'd0, d_port};
         alut_pkg::ra_inv_lo: reg_rdata = lst_inv_addr[31:0];
         alut_pkg::ra_inv_hi:
            reg_rdata = {14'd0, lst_inv_port, lst_inv_addr[alut_pkg::addr_w-1:32]};
         default:             reg_rdata = 32'd0;   // write only registers read zero
      endcase
   end

   // status read clears the reused flag
   assign clear_reused = reg_read && (reg_addr == alut_pkg::ra_status);

endmodule

/* logic/alut_top.sv */
module alut_top
(
   input  logic          pclk4,
   input  logic          n_p_reset4,
   input  logic          reg_write,
   input  logic          reg_read,
   input  logic [3:0]    reg_addr,
   input  logic [31:0]   reg_wdata,
   output logic [31:0]   reg_rdata
);

   // --------------------------------------------------
   // regs to checker and age checker
   // --------------------------------------------------
   logic [alut_pkg::addr_w-1:0]   mac_addr, d_addr, s_addr;
   logic [alut_pkg::port_w-1:0]   s_port;
   alut_pkg::cmd_e                command;
   logic [alut_pkg::time_w-1:0]   max_age;
   logic                          clear_reused;

   // checker results back to regs
   logic [alut_pkg::dport_w-1:0]  d_port;
   logic                          add_check_active, reused;
   logic [alut_pkg::addr_w-1:0]   lst_inv_addr;
   logic [alut_pkg::port_w-1:0]   lst_inv_port;

   // age handshake and time base
   logic                          check_age, age_confirmed, age_ok;
   logic [alut_pkg::time_w-1:0]   last_accessed, curr_time;

   // table port
   logic [alut_pkg::hash_w-1:0]   mem_addr;
   logic                          mem_write;
   logic [alut_pkg::entry_w-1:0]  mem_wdata, mem_rdata;

   alut_regs u_regs (.*);

   alut_addr_checker u_addr_checker (.*);

   alut_age_checker u_age_checker (.*);

   alut_mem u_mem (.*);

endmodule

/* tests/alut_properties.sv */
module alut_properties
(
   input logic          pclk4,
   input logic          n_p_reset4,
   input logic          reg_write,
   input logic          reg_read,
   input logic [3:0]    reg_addr,
   input logic [31:0]   reg_wdata,
   input logic [31:0]   reg_rdata
);

   int err_count = 0;                                    // bumped by every failing assertion

   logic [alut_pkg::time_w-1:0]  cyc;                    // runs in step with curr_time
   logic [alut_pkg::addr_w-1:0]  sh_mac, sh_d, sh_s;     // register copies
   logic [alut_pkg::port_w-1:0]  sh_sport;
   logic [alut_pkg::time_w-1:0]  sh_max_age;

   // --------------------------------------------------
   // shadow table
   // --------------------------------------------------
   logic [255:0]                 ent_vld;
   logic [alut_pkg::addr_w-1:0]  ent_addr [256];
   logic [alut_pkg::port_w-1:0]  ent_port [256];
   logic [alut_pkg::time_w-1:0]  ent_time [256];

   logic [alut_pkg::dport_w-1:0] exp_dport;
   logic                         exp_reused;
   logic [alut_pkg::addr_w-1:0]  exp_inv_addr;
   logic [alut_pkg::port_w-1:0]  exp_inv_port;
   logic [3:0]                   busy;                   // cycles left until idle
   logic                         cmd_q;                  // command pulse cycle, still idle
   logic                         cmd_hit, d_hit, exp_active;
   logic [7:0]                   hd, hs;
   logic [alut_pkg::time_w-1:0]  age;
   logic [alut_pkg::dport_w-1:0] src_mask;
   logic [31:0]                  exp_status, exp_inv_hi;

   function automatic logic [7:0] xor_fold(input logic [alut_pkg::addr_w-1:0] a);
      logic [7:0] h;
      h = 8'd0;
      for (int i = 0; i < 6; i++)
         h = h ^ a[i*8 +: 8];
      return h;
   endfunction

   assign cmd_hit  = reg_write && (reg_addr == alut_pkg::ra_command) &&
                     (reg_wdata[1:0] == alut_pkg::cmd_check);
   assign hd       = xor_fold(sh_d);
   assign hs       = xor_fold(sh_s);
   assign age      = (cyc + 32'd5) - ent_time[hd];       // age looked at 5 edges after command
   assign d_hit    = ent_vld[hd] && (ent_addr[hd] == sh_d) && (age <= sh_max_age);
   assign src_mask = alut_pkg::dport_w'(1) << sh_sport;
   assign exp_active = (busy != 4'd0) && !cmd_q;
   assign exp_status = {30'd0, exp_reused, exp_active};
   assign exp_inv_hi = {14'd0, exp_inv_port, exp_inv_addr[alut_pkg::addr_w-1:32]};

   always_ff @(posedge pclk4 or negedge n_p_reset4)
   begin
      if (!n_p_reset4)
      begin
         cyc <= '0;
         sh_mac <= '0;
         sh_d <= '0;
         sh_s <= '0;
         sh_sport <= '0;
         sh_max_age <= '0;
         ent_vld <= '0;                                  // table starts empty
         exp_dport <= alut_pkg::dport_all;
         exp_reused <= 1'b0;
         exp_inv_addr <= '0;
         exp_inv_port <= '0;
         busy <= '0;
         cmd_q <= 1'b0;
      end
      else
      begin
         cyc <= cyc + 1'b1;
         cmd_q <= cmd_hit;
         if (busy != 4'd0)
            busy <= busy - 1'b1;
         if (reg_write)
         begin
            case (reg_addr)
               alut_pkg::ra_mac_lo:  sh_mac[31:0] <= reg_wdata;
               alut_pkg::ra_mac_hi:  sh_mac[47:32] <= reg_wdata[15:0];
               alut_pkg::ra_d_lo:    sh_d[31:0] <= reg_wdata;
               alut_pkg::ra_d_hi:    sh_d[47:32] <= reg_wdata[15:0];
               alut_pkg::ra_s_lo:    sh_s[31:0] <= reg_wdata;
               alut_pkg::ra_s_hi:
               begin
                  sh_s[47:32] <= reg_wdata[15:0];
                  sh_sport <= reg_wdata[17:16];
               end
               alut_pkg::ra_max_age: sh_max_age <= reg_wdata;
               default: ;
            endcase
         end
         if (reg_read && (reg_addr == alut_pkg::ra_status))
            exp_reused <= 1'b0;                          // read to clear
         if (cmd_hit)
         begin
            if (sh_d == sh_mac)
            begin
               exp_dport <= alut_pkg::dport_cpu;         // own frame, nothing learned
               busy <= 4'd2;
            end
            else
            begin
               busy <= 4'd9;                             // eight active cycles follow
               if (d_hit)
                  exp_dport <= (alut_pkg::dport_w'(1) << ent_port[hd]) & ~src_mask;
               else
                  exp_dport <= alut_pkg::dport_all & ~src_mask;
               // overwrite of a different live address
               if (ent_vld[hs] && (ent_addr[hs] != sh_s))
               begin
                  exp_reused <= 1'b1;
                  exp_inv_addr <= ent_addr[hs];
                  exp_inv_port <= ent_port[hs];
               end
               ent_vld[hs] <= 1'b1;
               ent_addr[hs] <= sh_s;
               ent_port[hs] <= sh_sport;
               ent_time[hs] <= cyc + 32'd9;              // stamped at the end of write_src
            end
         end
      end
   end

   // --------------------------------------------------
   // read data checks
   // --------------------------------------------------
   property read_check(logic [3:0] ra, logic [31:0] exp);
      @(posedge pclk4) disable iff (!n_p_reset4)
      (reg_read && (reg_addr == ra)) |-> (reg_rdata == exp);
   endproperty

   status_read: assert property (read_check(alut_pkg::ra_status, exp_status))
   else
   begin
      err_count++;
      $error("MISMATCH %0t reg_rdata(status) got %h exp %h",
             $time, $sampled(reg_rdata), $sampled(exp_status));
   end

   dport_read: assert property (read_check(alut_pkg::ra_d_port, {27'd0, exp_dport}))
   else
   begin
      err_count++;
      $error("MISMATCH %0t reg_rdata(d_port) got %h exp %h",
             $time, $sampled(reg_rdata), $sampled(exp_dport));
   end

   inv_lo_read: assert property (read_check(alut_pkg::ra_inv_lo, exp_inv_addr[31:0]))
   else
   begin
      err_count++;
      $error("MISMATCH %0t reg_rdata(inv_lo) got %h exp %h",
             $time, $sampled(reg_rdata), $sampled(exp_inv_addr[31:0]));
   end

   inv_hi_read: assert property (read_check(alut_pkg::ra_inv_hi, exp_inv_hi))
   else
   begin
      err_count++;
      $error("MISMATCH %0t reg_rdata(inv_hi) got %h exp %h",
             $time, $sampled(reg_rdata), $sampled(exp_inv_hi));
   end

endmodule

bind alut_top alut_properties u_props (.*);

/* tests/alut_tb.sv */
module alut_tb;

   logic        pclk4;
   logic        n_p_reset4;
   logic        reg_write;
   logic        reg_read;
   logic [3:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;

   logic [31:0] rng = 32'd17830;                        // xorshift state
   int          timeouts = 0;
   int          total_errors;
   logic [47:0] mac, a, x, y;
   logic [1:0]  p, q;

   alut_top u_dut (.*);

   initial
   begin
      pclk4 = 1'b0;
      forever #10 pclk4 = ~pclk4;                       // period 20
   end

   // --------------------------------------------------
   // random values
   // --------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] v);
      logic [31:0] r;
      r = v ^ (v << 13);
      r = r ^ (r >> 17);
      r = r ^ (r << 5);
      return r;
   endfunction

   task automatic rand_addr(output logic [47:0] addr);
      rng = xorshift(rng);
      addr[31:0] = rng;
      rng = xorshift(rng);
      addr[47:32] = rng[15:0];
   endtask

   task automatic rand_port(output logic [1:0] port);
      rng = xorshift(rng);
      port = rng[9:8];
   endtask

   // byte xor, used to build a colliding address
   function automatic logic [7:0] fold_bytes(input logic [47:0] addr);
      logic [7:0] h;
      h = 8'd0;
      for (int i = 0; i < 6; i++)
         h = h ^ addr[i*8 +: 8];
      return h;
   endfunction

   // --------------------------------------------------
   // register bus, driven on the falling edge
   // --------------------------------------------------
   task automatic write_reg(input logic [3:0] ra, input logic [31:0] data);
      @(negedge pclk4);
      reg_write = 1'b1;
      reg_addr  = ra;
      reg_wdata = data;
      @(negedge pclk4);
      reg_write = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] ra);
      @(negedge pclk4);
      reg_read = 1'b1;
      reg_addr = ra;
      @(negedge pclk4);
      reg_read = 1'b0;
   endtask

   task automatic write_addr(input logic [3:0] ra_lo, input logic [3:0] ra_hi,
                             input logic [47:0] addr, input logic [1:0] port);
      write_reg(ra_lo, addr[31:0]);
      write_reg(ra_hi, {14'd0, port, addr[47:32]});     // port above the address
   endtask

   task automatic wait_active(input logic level);
      int n;
      n = 0;
      while ((u_dut.add_check_active !== level) && (n < 50))
      begin
         @(negedge pclk4);
         n++;
      end
      if (u_dut.add_check_active !== level)
      begin
         timeouts++;
         $display("timeout at %0t: checker active flag never became %0b", $time, level);
      end
   endtask

   // one lookup and learn, then fetch the port vector
   task automatic run_check(input logic [47:0] dst, input logic [47:0] src,
                            input logic [1:0] sport);
      write_addr(alut_pkg::ra_d_lo, alut_pkg::ra_d_hi, dst, 2'd0);
      write_addr(alut_pkg::ra_s_lo, alut_pkg::ra_s_hi, src, sport);
      write_reg(alut_pkg::ra_command, 32'(alut_pkg::cmd_check));
      wait_active(1'b1);
      wait_active(1'b0);
      read_reg(alut_pkg::ra_d_port);
   endtask

   // --------------------------------------------------
   // scenario
   // --------------------------------------------------
   initial
   begin
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      n_p_reset4 = 1'b0;
      repeat (8) @(negedge pclk4);
      n_p_reset4 = 1'b1;

      read_reg(alut_pkg::ra_status);                    // reset values
      read_reg(alut_pkg::ra_d_port);

      rand_addr(mac);
      write_addr(alut_pkg::ra_mac_lo, alut_pkg::ra_mac_hi, mac, 2'd0);
      write_reg(alut_pkg::ra_max_age, 32'hffff_ffff);
      rand_addr(a);
      rand_port(q);
      run_check(mac, a, q);                             // to the cpu
      rand_addr(x);
      rand_addr(a);
      rand_port(q);
      run_check(x, a, q);                               // unknown, flooded

      rand_addr(a);
      rand_port(p);
      rand_addr(x);
      run_check(x, a, p);                               // learn a on p
      rand_addr(x);
      rand_port(q);
      run_check(a, x, q);                               // hit from q

      write_reg(alut_pkg::ra_max_age, 32'd0);
      repeat (20) @(negedge pclk4);
      rand_addr(x);
      run_check(a, x, q);                               // now stale
      write_reg(alut_pkg::ra_max_age, 32'hffff_ffff);

      rand_addr(x);
      rand_port(p);
      rand_addr(a);
      run_check(a, x, p);
      rand_addr(y);
      rand_port(q);
      y[7:0] = y[7:0] ^ fold_bytes(y) ^ fold_bytes(x);   // same hash as x
      rand_addr(a);
      run_check(a, y, q);                               // overwrites x
      read_reg(alut_pkg::ra_status);
      read_reg(alut_pkg::ra_inv_lo);
      read_reg(alut_pkg::ra_inv_hi);
      read_reg(alut_pkg::ra_status);                    // flag cleared by the first read
      repeat (2) @(negedge pclk4);

      total_errors = u_dut.u_props.err_count + timeouts;
      $display("assertion errors %0d, timeouts %0d", u_dut.u_props.err_count, timeouts);
      if (total_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule
